//--- src.f
+incdir+.
mc_bus_pkg.sv
bus_req_decode.sv
bus_ram.sv
bus_timer.sv
bus_sim_ctrl.sv
bus_resp_route.sv
mc_bus_system.sv
tb_clk_gen.sv
tb_mc_bus_system.sv

//--- Makefile
# verilator flow for the shared bus testbench
# sim exits non-zero when the testbench stops with $fatal

TOP := tb_mc_bus_system

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- tb_mc_bus_system.sv
// ****************************************
// testbench for the shared bus system
// inputs change 1 ns after the rising edge
// response model runs on the falling edge
// stops at the first error
// ****************************************
`timescale 1ns/1ns
`default_nettype none
`include "mc_bus_settings.svh"

module tb_mc_bus_system;

  // about 80 accesses of 2 to 3 cycles each with a wide margin on top
  localparam int CycLimit = 2000;
  localparam int NrHosts  = `MC_NR_HOSTS;

  logic                                 clk;
  logic                                 rst_n;
  logic [NrHosts-1:0]                   host_req;
  logic [NrHosts-1:0]                   host_we;
  logic [NrHosts-1:0][`MC_DATA_W/8-1:0] host_be;
  logic [NrHosts-1:0][`MC_ADDR_W-1:0]   host_addr;
  mc_bus_pkg::bus_data_t [NrHosts-1:0]  host_wdata;
  logic [NrHosts-1:0]                   host_gnt;
  logic [NrHosts-1:0]                   host_rvalid;
  mc_bus_pkg::bus_data_t [NrHosts-1:0]  host_rdata;
  logic [NrHosts-1:0]                   host_err;
  logic                                 timer_irq;
  logic [7:0]                           char_data;
  logic                                 char_valid;
  logic                                 halt;

  logic [NrHosts-1:0]     exp_gnt;
  logic [3*NrHosts+2:0]   idle_flags;
  logic                   started = 1'b0;
  logic                   seen_req = 1'b0;
  int                     cyc = 0;
  // shadow ram and a flag for words with fully known contents
  mc_bus_pkg::bus_data_t  shadow [`MC_RAM_WORDS];
  logic                   shadow_ok [`MC_RAM_WORDS];
  // expected responses per host as {check data, err, data}
  logic [33:0]            exp_q [NrHosts][$];
  logic                   char_due = 1'b0;
  logic [7:0]             char_exp = 8'd0;
  logic                   halt_exp = 1'b0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mc_bus_system u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .host_req_i    (host_req),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .timer_irq_o   (timer_irq),
    .char_o        (char_data),
    .char_valid_o  (char_valid),
    .halt_o        (halt)
  );

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    $display("=== FAIL ===");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string what);
    $display("%0t %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  // enabled bytes from the new word and the rest kept
  function automatic mc_bus_pkg::bus_data_t merge_bytes(input mc_bus_pkg::bus_data_t old_w,
                                                        input mc_bus_pkg::bus_data_t new_w,
                                                        input logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] ram_addr(input int word);
    return `MC_RAM_BASE | (32'(word) << 2);
  endfunction

  // lowest set bit of the request vector wins
  assign exp_gnt    = host_req & (-host_req);
  assign idle_flags = {host_gnt, host_rvalid, host_err, timer_irq, char_valid, halt};

  always @(posedge clk) begin
    started <= 1'b1;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > CycLimit) begin
      abort_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  // quiet from reset until the first request
  assert property (@(posedge clk) (started && !seen_req) |-> (idle_flags == '0))
    else value_mismatch("idle outputs", 32'($sampled(idle_flags)), 32'd0);

  assert property (@(posedge clk) disable iff (!rst_n) host_gnt == exp_gnt)
    else value_mismatch("host_gnt_o", 32'($sampled(host_gnt)), 32'($sampled(exp_gnt)));

  // halt is sticky
  assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
    else value_mismatch("halt_o", 32'd0, 32'd1);

  for (genvar h = 0; h < NrHosts; h++) begin : g_host
    // response exactly one cycle after the grant and on the same host
    assert property (@(posedge clk) disable iff (!rst_n) host_gnt[h] |=> host_rvalid[h])
      else value_mismatch($sformatf("host_rvalid_o[%0d]", h), 32'd0, 32'd1);
    assert property (@(posedge clk) disable iff (!rst_n) host_rvalid[h] |-> $past(host_gnt[h]))
      else abort_run($sformatf("response on host %0d without a grant before it", h));
  end

  // response and side-effect model runs mid-cycle where all outputs are stable
  always @(negedge clk) begin : resp_model
    logic [33:0] ent;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    int          widx;
    logic        char_now;
    logic [7:0]  char_now_val;
    logic        halt_now;
    char_now     = 1'b0;
    char_now_val = 8'd0;
    halt_now     = 1'b0;
    if (rst_n) begin
      assert (char_valid == char_due)
        else value_mismatch("char_valid_o", 32'(char_valid), 32'(char_due));
      if (char_due) begin
        assert (char_data == char_exp)
          else value_mismatch("char_o", 32'(char_data), 32'(char_exp));
      end
      assert (halt == halt_exp) else value_mismatch("halt_o", 32'(halt), 32'(halt_exp));
      for (int h = 0; h < NrHosts; h++) begin
        if (host_rvalid[h]) begin
          assert (exp_q[h].size() > 0) else abort_run("response with no access in flight");
          ent = exp_q[h].pop_front();
          assert (host_err[h] == ent[32])
            else value_mismatch($sformatf("host_err_o[%0d]", h), 32'(host_err[h]), 32'(ent[32]));
          if (ent[33]) begin
            assert (host_rdata[h] == ent[31:0])
              else value_mismatch($sformatf("host_rdata_o[%0d]", h), host_rdata[h], ent[31:0]);
          end
        end
        if (host_gnt[h]) begin
          addr  = host_addr[h];
          wdata = host_wdata[h];
          be    = host_be[h];
          if ((addr & `MC_RAM_MASK) == `MC_RAM_BASE) begin
            // a write answers with the old word
            widx = int'((addr & ~`MC_RAM_MASK) >> 2);
            ent  = {shadow_ok[widx], 1'b0, shadow[widx]};
            if (host_we[h]) begin
              shadow[widx]    = merge_bytes(shadow[widx], wdata, be);
              shadow_ok[widx] = shadow_ok[widx] || (be == 4'hf);
            end
          end else if ((addr & `MC_SIMCTRL_MASK) == `MC_SIMCTRL_BASE) begin
            ent = {1'b1, 1'b0, 32'd0};
            if (host_we[h] && be[0]) begin
              if ((addr & ~`MC_SIMCTRL_MASK) == `MC_SIMCTRL_CHAR_OFS) begin
                char_now     = 1'b1;
                char_now_val = wdata[7:0];
              end
              if (((addr & ~`MC_SIMCTRL_MASK) == `MC_SIMCTRL_HALT_OFS) && wdata[0]) begin
                halt_now = 1'b1;
              end
            end
          end else if ((addr & `MC_TIMER_MASK) == `MC_TIMER_BASE) begin
            // mtime moves every cycle so the timer test checks the data
            ent = {1'b0, 1'b0, 32'd0};
          end else begin
            ent = {1'b1, 1'b1, 32'd0};
          end
          exp_q[h].push_back(ent);
        end
      end
      char_due = char_now;
      char_exp = char_now_val;
      halt_exp = halt_exp | halt_now;
    end
  end

  // one access held until granted with the response taken a cycle later
  task automatic bus_access(input int h, input logic we, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output mc_bus_pkg::bus_data_t rdata, output logic err,
                            output int gnt_cyc);
    @(posedge clk);
    #1;
    host_req[h]   = 1'b1;
    host_we[h]    = we;
    host_be[h]    = be;
    host_addr[h]  = addr;
    host_wdata[h] = wdata;
    seen_req      = 1'b1;
    @(negedge clk);
    while (!host_gnt[h]) begin
      @(negedge clk);
    end
    gnt_cyc = cyc;
    @(posedge clk);
    #1;
    host_req[h] = 1'b0;
    @(negedge clk);
    rdata = host_rdata[h];
    err   = host_err[h];
  endtask

  task automatic ram_test();
    int                    idx [16];
    int                    j;
    int                    gc;
    mc_bus_pkg::bus_data_t rd;
    logic                  err;
    // full words first so later partial writes merge into known data
    for (int i = 0; i < 16; i++) begin
      idx[i] = int'($urandom % `MC_RAM_WORDS);
      bus_access(int'($urandom % NrHosts), 1'b1, ram_addr(idx[i]), 4'hf, $urandom, rd, err, gc);
    end
    for (int i = 0; i < 24; i++) begin
      j = int'($urandom % 16);
      bus_access(int'($urandom % NrHosts), 1'b1, ram_addr(idx[j]), 4'($urandom), $urandom,
                 rd, err, gc);
    end
    for (int i = 0; i < 16; i++) begin
      bus_access(int'($urandom % NrHosts), 1'b0, ram_addr(idx[i]), 4'hf, 32'd0, rd, err, gc);
    end
  endtask

  task automatic priority_test();
    mc_bus_pkg::bus_data_t rd0;
    mc_bus_pkg::bus_data_t rd1;
    logic                  err0;
    logic                  err1;
    int                    gc0;
    int                    gc1;
    for (int i = 0; i < 4; i++) begin
      fork
        bus_access(0, 1'b0, ram_addr(i), 4'hf, 32'd0, rd0, err0, gc0);
        bus_access(1, 1'b1, ram_addr(i + 8), 4'hf, $urandom, rd1, err1, gc1);
      join
      assert (gc1 > gc0) else abort_run("host 1 granted no later than host 0");
    end
  endtask

  task automatic unmapped_test();
    mc_bus_pkg::bus_data_t rd;
    logic                  err;
    int                    gc;
    bus_access(0, 1'b0, 32'h0000_0000, 4'hf, 32'd0, rd, err, gc);
    bus_access(1, 1'b1, 32'h0004_0000, 4'hf, $urandom, rd, err, gc);
    // first word past the ram
    bus_access(0, 1'b0, `MC_RAM_BASE + 32'h1000, 4'hf, 32'd0, rd, err, gc);
    bus_access(1, 1'b0, 32'hF000_0000 | ($urandom & 32'h0FFF_FFFC), 4'hf, 32'd0, rd, err, gc);
  endtask

  task automatic timer_test();
    mc_bus_pkg::bus_data_t t0;
    mc_bus_pkg::bus_data_t t1;
    mc_bus_pkg::bus_data_t rd;
    logic                  err;
    int                    c0;
    int                    c1;
    bus_access(0, 1'b0, `MC_TIMER_BASE + `MC_TIMER_MTIME_OFS, 4'hf, 32'd0, t0, err, c0);
    repeat (int'($urandom % 8)) @(posedge clk);
    bus_access(0, 1'b0, `MC_TIMER_BASE + `MC_TIMER_MTIME_OFS, 4'hf, 32'd0, t1, err, c1);
    assert (t1 - t0 == 32'(c1 - c0))
      else value_mismatch("host_rdata_o[0] mtime delta", t1 - t0, 32'(c1 - c0));
    // irq follows the compare one cycle after the register loads
    bus_access(1, 1'b1, `MC_TIMER_BASE + `MC_TIMER_CMP_OFS, 4'hf, t1, rd, err, c0);
    @(negedge clk);
    assert (timer_irq == 1'b1) else value_mismatch("timer_irq_o", 32'(timer_irq), 32'd1);
    // moving the compare far ahead drops the level again
    bus_access(1, 1'b1, `MC_TIMER_BASE + `MC_TIMER_CMP_OFS, 4'hf, t1 + 32'h0001_0000,
               rd, err, c0);
    @(negedge clk);
    assert (timer_irq == 1'b0) else value_mismatch("timer_irq_o", 32'(timer_irq), 32'd0);
  endtask

  task automatic sim_ctrl_test();
    mc_bus_pkg::bus_data_t rd;
    logic                  err;
    int                    gc;
    for (int i = 0; i < 3; i++) begin
      bus_access(i % NrHosts, 1'b1, `MC_SIMCTRL_BASE + `MC_SIMCTRL_CHAR_OFS, 4'h1,
                 32'h41 + ($urandom % 26), rd, err, gc);
    end
    bus_access(0, 1'b0, `MC_SIMCTRL_BASE + `MC_SIMCTRL_CHAR_OFS, 4'hf, 32'd0, rd, err, gc);
    // bit 0 clear leaves halt low
    bus_access(1, 1'b1, `MC_SIMCTRL_BASE + `MC_SIMCTRL_HALT_OFS, 4'hf, 32'h2, rd, err, gc);
    bus_access(0, 1'b1, `MC_SIMCTRL_BASE + `MC_SIMCTRL_HALT_OFS, 4'hf, 32'h1, rd, err, gc);
    repeat (4) @(negedge clk);
    assert (halt == 1'b1) else value_mismatch("halt_o", 32'(halt), 32'd1);
  endtask

  initial begin
    void'($urandom(32'hae58));
    host_req   = '0;
    host_we    = '0;
    host_be    = '0;
    host_addr  = '0;
    host_wdata = '0;
    foreach (shadow_ok[i]) begin
      shadow_ok[i] = 1'b0;
    end
    wait (rst_n === 1'b1);
    // a few idle cycles for the quiet check
    repeat (3) @(posedge clk);
    ram_test();
    priority_test();
    unmapped_test();
    timer_test();
    sim_ctrl_test();
    repeat (2) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// ****************************************
// testbench clock, 4 ns period
// reset low for the first 4 rising edges
// release lands 1 ns after an edge
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

  // same offset as the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- mc_bus_system.sv
// ****************************************
// shared bus with ram, timer and sim ctrl
// hosts hold requests until granted
// every response comes one cycle after grant
// ****************************************
`timescale 1ns/1ns
`default_nettype none
`include "mc_bus_settings.svh"

module mc_bus_system (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                  [`MC_NR_HOSTS-1:0]     host_req_i,
  input  logic                  [`MC_NR_HOSTS-1:0]     host_we_i,
  input  mc_bus_pkg::bus_be_t   [`MC_NR_HOSTS-1:0]     host_be_i,
  input  mc_bus_pkg::bus_addr_t [`MC_NR_HOSTS-1:0]     host_addr_i,
  input  mc_bus_pkg::bus_data_t [`MC_NR_HOSTS-1:0]     host_wdata_i,
  output logic                  [`MC_NR_HOSTS-1:0]     host_gnt_o,
  output logic                  [`MC_NR_HOSTS-1:0]     host_rvalid_o,
  output mc_bus_pkg::bus_data_t [`MC_NR_HOSTS-1:0]     host_rdata_o,
  output logic                  [`MC_NR_HOSTS-1:0]     host_err_o,
  output logic                                         timer_irq_o,
  output logic                  [7:0]                  char_o,
  output logic                                         char_valid_o,
  output logic                                         halt_o
);

  // decoder to devices
  logic                  [`MC_NR_DEVS-1:0] dev_req;
  logic                                    dev_we;
  mc_bus_pkg::bus_be_t                     dev_be;
  mc_bus_pkg::bus_addr_t                   dev_addr;
  mc_bus_pkg::bus_data_t                   dev_wdata;
  // devices to router
  logic                  [`MC_NR_DEVS-1:0] dev_rvalid;
  mc_bus_pkg::bus_data_t [`MC_NR_DEVS-1:0] dev_rdata;
  // decoder to router
  mc_bus_pkg::host_idx_t                   resp_host;
  mc_bus_pkg::dev_sel_e                    resp_sel;
  logic                                    resp_pending;

  bus_req_decode u_decode (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .host_req_i     (host_req_i),
    .host_we_i      (host_we_i),
    .host_be_i      (host_be_i),
    .host_addr_i    (host_addr_i),
    .host_wdata_i   (host_wdata_i),
    .host_gnt_o     (host_gnt_o),
    .dev_req_o      (dev_req),
    .dev_we_o       (dev_we),
    .dev_be_o       (dev_be),
    .dev_addr_o     (dev_addr),
    .dev_wdata_o    (dev_wdata),
    .resp_host_o    (resp_host),
    .resp_sel_o     (resp_sel),
    .resp_pending_o (resp_pending)
  );

  bus_ram u_ram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (dev_req[mc_bus_pkg::DevRam]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (dev_rvalid[mc_bus_pkg::DevRam]),
    .rdata_o  (dev_rdata[mc_bus_pkg::DevRam])
  );

  bus_sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (dev_req[mc_bus_pkg::DevSimCtrl]),
    .we_i         (dev_we),
    .be_i         (dev_be),
    .addr_i       (dev_addr),
    .wdata_i      (dev_wdata),
    .rvalid_o     (dev_rvalid[mc_bus_pkg::DevSimCtrl]),
    .rdata_o      (dev_rdata[mc_bus_pkg::DevSimCtrl]),
    .char_o       (char_o),
    .char_valid_o (char_valid_o),
    .halt_o       (halt_o)
  );

  bus_timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (dev_req[mc_bus_pkg::DevTimer]),
    .we_i        (dev_we),
    .be_i        (dev_be),
    .addr_i      (dev_addr),
    .wdata_i     (dev_wdata),
    .rvalid_o    (dev_rvalid[mc_bus_pkg::DevTimer]),
    .rdata_o     (dev_rdata[mc_bus_pkg::DevTimer]),
    .timer_irq_o (timer_irq_o)
  );

  bus_resp_route u_route (
    .resp_host_i    (resp_host),
    .resp_sel_i     (resp_sel),
    .resp_pending_i (resp_pending),
    .dev_rvalid_i   (dev_rvalid),
    .dev_rdata_i    (dev_rdata),
    .host_rvalid_o  (host_rvalid_o),
    .host_rdata_o   (host_rdata_o),
    .host_err_o     (host_err_o)
  );

endmodule

`default_nettype wire

//--- bus_resp_route.sv
// ****************************************
// response steering back to granted host
// unmapped access answers err with zero data
// purely combinational
// ****************************************
`timescale 1ns/1ns
`default_nettype none
`include "mc_bus_settings.svh"

module bus_resp_route (
  input  mc_bus_pkg::host_idx_t                        resp_host_i,
  input  mc_bus_pkg::dev_sel_e                         resp_sel_i,
  input  logic                                         resp_pending_i,
  input  logic                  [`MC_NR_DEVS-1:0]      dev_rvalid_i,
  input  mc_bus_pkg::bus_data_t [`MC_NR_DEVS-1:0]      dev_rdata_i,
  output logic                  [`MC_NR_HOSTS-1:0]     host_rvalid_o,
  output mc_bus_pkg::bus_data_t [`MC_NR_HOSTS-1:0]     host_rdata_o,
  output logic                  [`MC_NR_HOSTS-1:0]     host_err_o
);

  logic                  rsp_valid;
  mc_bus_pkg::bus_data_t rsp_data;
  logic                  rsp_err;

  // pick the response of the recorded target
  always_comb begin
    rsp_valid = 1'b0;
    rsp_data  = '0;
    rsp_err   = 1'b0;
    if (resp_pending_i) begin
      if (resp_sel_i == mc_bus_pkg::DevNone) begin
        rsp_valid = 1'b1;
        rsp_err   = 1'b1;
      end else begin
        for (int d = 0; d < `MC_NR_DEVS; d++) begin
          if (resp_sel_i == mc_bus_pkg::dev_sel_e'(d)) begin
            rsp_valid = dev_rvalid_i[d];
            rsp_data  = dev_rdata_i[d];
          end
        end
      end
    end
  end

  // only the recorded host sees it
  always_comb begin
    host_rvalid_o = '0;
    host_rdata_o  = '0;
    host_err_o    = '0;
    host_rvalid_o[resp_host_i] = rsp_valid;
    host_rdata_o[resp_host_i]  = rsp_data;
    host_err_o[resp_host_i]    = rsp_err;
  end

endmodule

`default_nettype wire

//--- bus_sim_ctrl.sv
// ****************************************
// char output strobe and sticky halt flag
// writes need byte lane 0 enabled
// reads return zero
// ****************************************
`timescale 1ns/1ns
`default_nettype none
`include "mc_bus_settings.svh"

module bus_sim_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  mc_bus_pkg::bus_be_t   be_i,
  input  mc_bus_pkg::bus_addr_t addr_i,
  input  mc_bus_pkg::bus_data_t wdata_i,
  output logic                  rvalid_o,
  output mc_bus_pkg::bus_data_t rdata_o,
  output logic [7:0]            char_o,
  output logic                  char_valid_o,
  output logic                  halt_o
);

  mc_bus_pkg::bus_addr_t ofs;
  logic                  wr_lane0;
  logic                  wr_char;
  logic                  wr_halt;
  logic [7:0]            char_q;
  logic                  char_valid_q;
  logic                  halt_q;
  logic                  rvalid_q;

  assign ofs      = addr_i & ~`MC_SIMCTRL_MASK;
  assign wr_lane0 = req_i && we_i && be_i[0];
  assign wr_char  = wr_lane0 && (ofs == `MC_SIMCTRL_CHAR_OFS);
  assign wr_halt  = wr_lane0 && (ofs == `MC_SIMCTRL_HALT_OFS) && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      // one-cycle strobe per char write
      char_valid_q <= wr_char;
      // sticky until reset
      halt_q       <= halt_q | wr_halt;
      rvalid_q     <= req_i;
    end
  end

  // char byte held between writes
  always_ff @(posedge clk_i) begin
    if (wr_char) begin
      char_q <= wdata_i[7:0];
    end
  end

  assign rvalid_o     = rvalid_q;
  assign rdata_o      = '0;
  assign char_o       = char_q;
  assign char_valid_o = char_valid_q;
  assign halt_o       = halt_q;

endmodule

`default_nettype wire

//--- bus_timer.sv
// ****************************************
// 32-bit mtime and compare, both writable
// mtime counts every cycle, write wins
// irq is registered, lags compare by one
// ****************************************
`timescale 1ns/1ns
`default_nettype none
`include "mc_bus_settings.svh"

module bus_timer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  mc_bus_pkg::bus_be_t   be_i,
  input  mc_bus_pkg::bus_addr_t addr_i,
  input  mc_bus_pkg::bus_data_t wdata_i,
  output logic                  rvalid_o,
  output mc_bus_pkg::bus_data_t rdata_o,
  output logic                  timer_irq_o
);

  mc_bus_pkg::bus_addr_t ofs;
  logic                  hit_mtime;
  logic                  hit_cmp;
  mc_bus_pkg::bus_data_t mtime_q;
  mc_bus_pkg::bus_data_t cmp_q;
  mc_bus_pkg::bus_data_t rdata_q;
  logic                  rvalid_q;
  logic                  irq_q;

  // offset inside the 1 kB region
  assign ofs       = addr_i & ~`MC_TIMER_MASK;
  assign hit_mtime = req_i && (ofs == `MC_TIMER_MTIME_OFS);
  assign hit_cmp   = req_i && (ofs == `MC_TIMER_CMP_OFS);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_q  <= '0;
      cmp_q    <= '1;
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (hit_mtime && we_i) begin
        mtime_q <= mc_bus_pkg::be_merge(mtime_q, wdata_i, be_i);
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (hit_cmp && we_i) begin
        cmp_q <= mc_bus_pkg::be_merge(cmp_q, wdata_i, be_i);
      end
      // level stays high while mtime >= cmp
      irq_q    <= (mtime_q >= cmp_q);
      rvalid_q <= req_i;
    end
  end

  // value sampled in the request cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (hit_mtime) begin
        rdata_q <= mtime_q;
      end else if (hit_cmp) begin
        rdata_q <= cmp_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

//--- bus_ram.sv
// ****************************************
// single port word ram, one cycle latency
// index is the word offset in the region
// contents survive reset
// ****************************************
`timescale 1ns/1ns
`default_nettype none
`include "mc_bus_settings.svh"

module bus_ram (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  mc_bus_pkg::bus_be_t   be_i,
  input  mc_bus_pkg::bus_addr_t addr_i,
  input  mc_bus_pkg::bus_data_t wdata_i,
  output logic                  rvalid_o,
  output mc_bus_pkg::bus_data_t rdata_o
);

  localparam int unsigned RamAw = $clog2(`MC_RAM_WORDS);

  mc_bus_pkg::bus_data_t mem [`MC_RAM_WORDS];
  logic [RamAw-1:0]      word_idx;
  mc_bus_pkg::bus_data_t rdata_q;
  logic                  rvalid_q;

  // drop the byte offset
  assign word_idx = addr_i[RamAw+1:2];

  // read returns old word, also on a write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[word_idx] <= mc_bus_pkg::be_merge(mem[word_idx], wdata_i, be_i);
      end
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

//--- bus_req_decode.sv
// ****************************************
// fixed priority, lowest host index wins
// grant and device request are combinational
// one transaction in flight, latency 1
// ****************************************
`timescale 1ns/1ns
`default_nettype none
`include "mc_bus_settings.svh"

module bus_req_decode (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                  [`MC_NR_HOSTS-1:0]     host_req_i,
  input  logic                  [`MC_NR_HOSTS-1:0]     host_we_i,
  input  mc_bus_pkg::bus_be_t   [`MC_NR_HOSTS-1:0]     host_be_i,
  input  mc_bus_pkg::bus_addr_t [`MC_NR_HOSTS-1:0]     host_addr_i,
  input  mc_bus_pkg::bus_data_t [`MC_NR_HOSTS-1:0]     host_wdata_i,
  output logic                  [`MC_NR_HOSTS-1:0]     host_gnt_o,
  output logic                  [`MC_NR_DEVS-1:0]      dev_req_o,
  output logic                                         dev_we_o,
  output mc_bus_pkg::bus_be_t                          dev_be_o,
  output mc_bus_pkg::bus_addr_t                        dev_addr_o,
  output mc_bus_pkg::bus_data_t                        dev_wdata_o,
  output mc_bus_pkg::host_idx_t                        resp_host_o,
  output mc_bus_pkg::dev_sel_e                         resp_sel_o,
  output logic                                         resp_pending_o
);

  mc_bus_pkg::host_idx_t win_idx;
  logic                  any_req;
  mc_bus_pkg::bus_addr_t win_addr;
  mc_bus_pkg::dev_sel_e  win_sel;
  mc_bus_pkg::host_idx_t host_q;
  mc_bus_pkg::dev_sel_e  sel_q;
  logic                  pending_q;

  // scan downwards so the lowest requester is the last to stick
  always_comb begin
    win_idx = '0;
    any_req = 1'b0;
    for (int h = `MC_NR_HOSTS-1; h >= 0; h--) begin
      if (host_req_i[h]) begin
        win_idx = mc_bus_pkg::host_idx_t'(h);
        any_req = 1'b1;
      end
    end
  end

  assign win_addr = host_addr_i[win_idx];

  // base/mask match, regions do not overlap
  always_comb begin
    if ((win_addr & `MC_RAM_MASK) == `MC_RAM_BASE) begin
      win_sel = mc_bus_pkg::DevRam;
    end else if ((win_addr & `MC_SIMCTRL_MASK) == `MC_SIMCTRL_BASE) begin
      win_sel = mc_bus_pkg::DevSimCtrl;
    end else if ((win_addr & `MC_TIMER_MASK) == `MC_TIMER_BASE) begin
      win_sel = mc_bus_pkg::DevTimer;
    end else begin
      win_sel = mc_bus_pkg::DevNone;
    end
  end

  // grant to winner, one-hot request to the hit device
  always_comb begin
    host_gnt_o = '0;
    if (any_req) begin
      host_gnt_o[win_idx] = 1'b1;
    end
    for (int d = 0; d < `MC_NR_DEVS; d++) begin
      dev_req_o[d] = any_req && (win_sel == mc_bus_pkg::dev_sel_e'(d));
    end
  end

  // request fields broadcast, only the selected device looks
  assign dev_we_o    = host_we_i[win_idx];
  assign dev_be_o    = host_be_i[win_idx];
  assign dev_addr_o  = win_addr;
  assign dev_wdata_o = host_wdata_i[win_idx];

  // routing of the response due next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      host_q    <= '0;
      sel_q     <= mc_bus_pkg::DevNone;
    end else begin
      pending_q <= any_req;
      if (any_req) begin
        host_q <= win_idx;
        sel_q  <= win_sel;
      end
    end
  end

  assign resp_host_o    = host_q;
  assign resp_sel_o     = sel_q;
  assign resp_pending_o = pending_q;

endmodule

`default_nettype wire

//--- mc_bus_pkg.sv
// ****************************************
// bus types shared by all bus blocks
// device enum values index the device arrays
// ****************************************
`default_nettype none
`include "mc_bus_settings.svh"

package mc_bus_pkg;

  typedef logic [`MC_ADDR_W-1:0] bus_addr_t;
  typedef logic [`MC_DATA_W-1:0] bus_data_t;
  typedef logic [`MC_DATA_W/8-1:0] bus_be_t;
  typedef logic [$clog2(`MC_NR_HOSTS)-1:0] host_idx_t;

  // decoded target, DevNone is an unmapped address
  typedef enum logic [1:0] {
    DevRam     = 2'd0,
    DevSimCtrl = 2'd1,
    DevTimer   = 2'd2,
    DevNone    = 2'd3
  } dev_sel_e;

  // byte-enable merge of a write into a stored word
  function automatic bus_data_t be_merge(input bus_data_t old_d, input bus_data_t new_d,
                                         input bus_be_t be);
    bus_data_t res;
    res = old_d;
    for (int b = 0; b < `MC_DATA_W/8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- mc_bus_settings.svh
// ****************************************
// address map and sizes of the shared bus
// masks keep the bits that must match base
// ram size must stay a power of two
// ****************************************
`ifndef MC_BUS_SETTINGS_SVH
`define MC_BUS_SETTINGS_SVH

// bus geometry
`define MC_NR_HOSTS 2
`define MC_NR_DEVS 3
`define MC_ADDR_W 32
`define MC_DATA_W 32

// device regions
`define MC_RAM_BASE 32'h0010_0000
`define MC_RAM_MASK 32'hFFFF_F000
`define MC_RAM_WORDS 1024
`define MC_SIMCTRL_BASE 32'h0002_0000
`define MC_SIMCTRL_MASK 32'hFFFF_FC00
`define MC_TIMER_BASE 32'h0003_0000
`define MC_TIMER_MASK 32'hFFFF_FC00

// register offsets inside a region
`define MC_TIMER_MTIME_OFS 32'h0
`define MC_TIMER_CMP_OFS 32'h4
`define MC_SIMCTRL_CHAR_OFS 32'h0
`define MC_SIMCTRL_HALT_OFS 32'h8

`endif
